//--- addrDecode.sv
//##########################################################################
// Top-level region decoder with boot overlay and read-only ROM
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module addrDecode (
  input  busPkg::cpuBusT    cpuBus,
  input  logic              bootFetch,
  output sysMapPkg::memSelT memSel
);

  import sysMapPkg::*;
  import busPkg::*;

  logic [regionHiBit:regionLoBit]   regionBits;
  logic [bankHiBit-bankLoBit:0]     bank;
  logic                             spaceOk;
  logic                             romHit;
  logic                             devHit;
  logic                             mmioHit;
  logic                             dramHit;

  // Masked compare over the region window
  function automatic logic regionMatch(
    input logic [regionHiBit:regionLoBit] bits,
    input logic [regionHiBit:regionLoBit] base,
    input logic [regionHiBit:regionLoBit] mask
  );
    return (bits & mask) == (base & mask);
  endfunction

  assign regionBits = cpuBus.addr[regionHiBit:regionLoBit];
  assign bank       = cpuBus.addr[bankHiBit:bankLoBit];

  // Only user/supervisor data and program spaces
  // CPU space and reserved codes select nothing
  always_comb begin
    case (cpuBus.fc)
      userData, userProg, superData, superProg: spaceOk = 1'b1;
      default:                                  spaceOk = 1'b0;
    endcase
  end

  assign romHit  = regionMatch(regionBits, romBase[regionHiBit:regionLoBit],
                               romMask[regionHiBit:regionLoBit]);
  assign devHit  = regionMatch(regionBits, devBase[regionHiBit:regionLoBit],
                               devMask[regionHiBit:regionLoBit]);
  assign mmioHit = regionMatch(regionBits, mmioBase[regionHiBit:regionLoBit],
                               mmioMask[regionHiBit:regionLoBit]);
  assign dramHit = regionMatch(regionBits, dramBase[regionHiBit:regionLoBit],
                               dramMask[regionHiBit:regionLoBit]);

  always_comb begin
    memSel = '0;
    if (!cpuBus.nAs && spaceOk) begin
      // ROM drives the bus on reads only
      memSel.rom  = romHit & cpuBus.rnW;
      memSel.dev  = devHit;
      memSel.mmio = mmioHit;
      if (dramHit) begin
        // Reset vector fetch comes from ROM while booting
        if (bootFetch && bank == '0) begin
          memSel.rom = cpuBus.rnW;
        end else begin
          memSel.dram[bank] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- busMonitor.sv
//##########################################################################
// Bus cycle end detect, boot cycle counter, bus error watchdog
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module busMonitor (
  input  logic           CPU_CLK,
  input  logic           nRST,
  input  busPkg::cpuBusT cpuBus,
  output logic           bootFetch,
  output logic           berr
);

  import busPkg::*;

  logic             nAsQ;
  logic             cycleEnd;
  logic [bootW-1:0] bootCnt;
  logic [berrW-1:0] berrCnt;

  // nAs seen high after being low
  assign cycleEnd = ~nAsQ & cpuBus.nAs;

  // Saturates at bootCycles
  always_ff @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST) begin
      nAsQ    <= 1'b1;
      bootCnt <= '0;
    end else begin
      nAsQ <= cpuBus.nAs;
      if (cycleEnd && bootFetch) begin
        bootCnt <= bootCnt + 1'b1;
      end
    end
  end

  assign bootFetch = (bootCnt != bootCycles);

  // Watchdog, idle while nAs is high
  always_ff @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST) begin
      berrCnt <= '0;
    end else if (cpuBus.nAs) begin
      berrCnt <= '0;
    end else if (berrCnt != berrLimit) begin
      berrCnt <= berrCnt + 1'b1;
    end
  end

  // Held until the CPU drops the cycle
  assign berr = ~cpuBus.nAs & (berrCnt == berrLimit);

endmodule

`default_nettype wire

//--- busPkg.sv
//##########################################################################
// CPU bus struct, function codes, DSACK codes, cycle states, bus timing
//##########################################################################
`default_nettype none

package busPkg;

  // Address width of the 68030 bus
  localparam int addrW = 32;

  // FC2..FC0 address spaces
  typedef enum logic [2:0] {
    reserved0 = 3'd0,
    userData  = 3'd1,
    userProg  = 3'd2,
    reserved3 = 3'd3,
    reserved4 = 3'd4,
    superData = 3'd5,
    superProg = 3'd6,
    cpuSpace  = 3'd7
  } fcT;

  // CPU side of the bus, strobes active low as on the pins
  typedef struct packed {
    logic             nAs;
    logic             nDs;
    logic             rnW;
    logic [1:0]       siz;
    fcT               fc;
    logic [addrW-1:0] addr;
  } cpuBusT;

  // DSACK1/DSACK0 port size, active high here
  typedef enum logic [1:0] {
    portNone = 2'b00,
    port8    = 2'b01,
    port16   = 2'b10
  } portT;

  // Bus-cycle controller states
  typedef enum logic [3:0] {
    idle,
    romWait,
    duartWait,
    tmrSetup,
    tmrHold1,
    tmrHold2,
    tmrAck,
    tmrRecover1,
    tmrRecover2,
    finish
  } cycStateT;

  // Boot overlay covers the reset vector fetch
  localparam int bootW = 3;
  localparam logic [bootW-1:0] bootCycles = 3'd4;

  // Bus error watchdog
  localparam int berrW = 6;
  localparam logic [berrW-1:0] berrLimit = 6'd63;

endpackage

`default_nettype wire

//--- cycleCtrl.sv
//##########################################################################
// Bus-cycle FSM for ROM, DUART and timer: DSACK, I/O strobes, recovery
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cycleCtrl (
  input  logic              CPU_CLK,
  input  logic              nRST,
  input  busPkg::cpuBusT    cpuBus,
  input  sysMapPkg::memSelT memSel,
  input  sysMapPkg::devSelT devSel,
  output busPkg::portT      dsack,
  output logic              ioRd,
  output logic              ioWr
);

  import busPkg::*;

  cycStateT state;
  portT     dsackQ;
  logic     strobeD;
  logic     ioStrobe;

  always_ff @(posedge CPU_CLK or negedge nRST) begin
    if (!nRST) begin
      state   <= idle;
      dsackQ  <= portNone;
      strobeD <= 1'b0;
    end else begin
      case (state)
        idle: begin
          // Start only once data strobe is down
          if (!cpuBus.nDs) begin
            if (memSel.rom) begin
              // 70 ns flash, one wait state
              state <= romWait;
            end else if (devSel.duart && cpuBus.rnW) begin
              // DUART read, zero wait
              dsackQ <= port8;
              state  <= finish;
            end else if (devSel.duart) begin
              state <= duartWait;
            end else if (devSel.tmr && cpuBus.rnW) begin
              // 82C54 needs address setup before the read strobe
              state <= tmrSetup;
            end else if (devSel.tmr) begin
              // CPU already delays nDs on writes
              state <= tmrHold1;
            end
          end
        end

        romWait: begin
          dsackQ <= port16;
          state  <= finish;
        end

        duartWait: begin
          dsackQ <= port8;
          state  <= finish;
        end

        tmrSetup: begin
          // Release the delayed read strobe
          strobeD <= 1'b1;
          state   <= tmrHold1;
        end

        // Strobe pulse width
        tmrHold1: state <= tmrHold2;
        tmrHold2: state <= tmrAck;

        tmrAck: begin
          // Raise DSACK first, then hold it until nDs goes up
          if (dsackQ == portNone) begin
            dsackQ <= port8;
          end else if (cpuBus.nDs) begin
            dsackQ  <= portNone;
            strobeD <= 1'b0;
            state   <= tmrRecover1;
          end
        end

        // Timer recovery time, a back-to-back access may follow
        tmrRecover1: state <= tmrRecover2;
        tmrRecover2: state <= idle;

        finish: begin
          if (cpuBus.nDs) begin
            dsackQ <= portNone;
            state  <= idle;
          end
        end

        default: state <= idle;
      endcase
    end
  end

  // Drops with nDs, without waiting for the clock
  assign dsack = cpuBus.nDs ? portNone : dsackQ;

  // Off-board devices get the strobe straight away
  // timer reads wait for the delayed copy
  assign ioStrobe = devSel.ext | (devSel.tmr & ~cpuBus.rnW) | strobeD;

  assign ioRd = ioStrobe & ~cpuBus.nDs & cpuBus.rnW;
  assign ioWr = ioStrobe & ~cpuBus.nDs & ~cpuBus.rnW;

endmodule

`default_nettype wire

//--- devDecode.sv
//##########################################################################
// Peripheral sub-decoder and external device select
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module devDecode (
  input  busPkg::cpuBusT    cpuBus,
  input  sysMapPkg::memSelT memSel,
  output sysMapPkg::devSelT devSel
);

  import sysMapPkg::*;

  logic [devAddrW-1:devLoBit] ofs;
  logic                       duartHit;
  logic                       tmrHit;
  logic                       ataHit;
  logic                       i2cHit;
  logic                       intcHit;

  // Offset within DEV space, 16-byte granules
  assign ofs = cpuBus.addr[devAddrW-1:devLoBit];

  assign duartHit = (ofs == duartOfs[devAddrW-1:devLoBit]);
  assign tmrHit   = (ofs == tmrOfs[devAddrW-1:devLoBit]);
  assign ataHit   = (ofs == ataOfs[devAddrW-1:devLoBit]);
  assign i2cHit   = (ofs == i2cOfs[devAddrW-1:devLoBit]);
  assign intcHit  = (ofs == intcOfs[devAddrW-1:devLoBit]);

  assign devSel.duart = memSel.dev & duartHit;
  assign devSel.tmr   = memSel.dev & tmrHit;
  assign devSel.ata   = memSel.dev & ataHit;
  // PCF8584 picks its 68000 interface mode from CS vs DS
  // so hold off the select until nDs is low
  assign devSel.i2c   = memSel.dev & i2cHit & ~cpuBus.nDs;
  assign devSel.intc  = memSel.dev & intcHit;

  // Everything else in DEV space is decoded off-board
  assign devSel.ext = memSel.dev & ~(duartHit | tmrHit | ataHit | i2cHit | intcHit);

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build the sysCtl testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbSysCtl -f sysCtl.f -o simSysCtl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simSysCtl > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$logFile"; then
  exit 0
fi
echo "Pass message not found in $logFile"
exit 1

//--- sysCtl.f
+incdir+.
sysMapPkg.sv
busPkg.sv
addrDecode.sv
devDecode.sv
busMonitor.sv
cycleCtrl.sv
sysCtl.sv
tbSysCtl.sv

//--- sysCtl.sv
//##########################################################################
// System controller top: decoders, bus monitor, bus-cycle controller
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module sysCtl (
  input  logic              CPU_CLK,
  input  logic              nRST,
  input  busPkg::cpuBusT    cpuBus,
  output sysMapPkg::memSelT memSel,
  output sysMapPkg::devSelT devSel,
  output busPkg::portT      dsack,
  output logic              ci,
  output logic              berr,
  output logic              ioRd,
  output logic              ioWr
);

  logic bootFetch;

  // Region decode, ROM overlays bank 0 while booting
  addrDecode addrDecode_i (
    .cpuBus    (cpuBus),
    .bootFetch (bootFetch),
    .memSel    (memSel)
  );

  // DEV space devices
  devDecode devDecode_i (
    .cpuBus (cpuBus),
    .memSel (memSel),
    .devSel (devSel)
  );

  // Boot counter and watchdog
  busMonitor busMonitor_i (
    .CPU_CLK   (CPU_CLK),
    .nRST      (nRST),
    .cpuBus    (cpuBus),
    .bootFetch (bootFetch),
    .berr      (berr)
  );

  // Termination for devices without a native 68k bus
  cycleCtrl cycleCtrl_i (
    .CPU_CLK (CPU_CLK),
    .nRST    (nRST),
    .cpuBus  (cpuBus),
    .memSel  (memSel),
    .devSel  (devSel),
    .dsack   (dsack),
    .ioRd    (ioRd),
    .ioWr    (ioWr)
  );

  // No caching of the boot fetch or of peripheral space
  assign ci = bootFetch | memSel.dev;

endmodule

`default_nettype wire

//--- sysMapPkg.sv
//##########################################################################
// Address map, region patterns, peripheral offsets and select structs
//##########################################################################
`default_nettype none

package sysMapPkg;

  // CPU address width
  localparam int addrW = 32;

  // Top-level region compare window
  localparam int regionHiBit = 31;
  localparam int regionLoBit = 13;

  // Four 256 MB DRAM banks
  localparam int dramBanks = 4;
  localparam int bankHiBit = 29;
  localparam int bankLoBit = 28;

  // Region patterns, each with its compare mask
  // ROM and DEV are 1 MB each at the top of the map
  localparam logic [addrW-1:0] romBase  = 32'hFFF0_0000;
  localparam logic [addrW-1:0] romMask  = 32'hFFF0_0000;
  localparam logic [addrW-1:0] devBase  = 32'hFFE0_0000;
  localparam logic [addrW-1:0] devMask  = 32'hFFF0_0000;
  // MMIO and DRAM take 1 GB each
  localparam logic [addrW-1:0] mmioBase = 32'h8000_0000;
  localparam logic [addrW-1:0] mmioMask = 32'hC000_0000;
  localparam logic [addrW-1:0] dramBase = 32'h0000_0000;
  localparam logic [addrW-1:0] dramMask = 32'hC000_0000;

  // Peripheral space offsets, matched on bits 19:4
  localparam int devAddrW = 20;
  localparam int devLoBit = 4;
  localparam logic [devAddrW-1:0] duartOfs = 20'h00000;
  localparam logic [devAddrW-1:0] tmrOfs   = 20'h00010;
  localparam logic [devAddrW-1:0] ataOfs   = 20'h00020;
  localparam logic [devAddrW-1:0] i2cOfs   = 20'h00100;
  localparam logic [devAddrW-1:0] intcOfs  = 20'hFFFF0;

  // Top-level selects, active high
  typedef struct packed {
    logic                 rom;
    logic                 dev;
    logic                 mmio;
    logic [dramBanks-1:0] dram;
  } memSelT;

  // Peripheral selects; ext covers anything not decoded here
  typedef struct packed {
    logic duart;
    logic tmr;
    logic ata;
    logic i2c;
    logic intc;
    logic ext;
  } devSelT;

endpackage

`default_nettype wire

//--- tbVectors.svh
//##########################################################################
// Bus-cycle vector type, expected select patterns and the vector table
//##########################################################################
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One bus cycle with random address bits under the mask
typedef struct packed {
  logic [31:0] base;
  logic [31:0] mask;
  fcT          fc;
  logic        rnW;
  logic [1:0]  siz;
  memSelT      mem;
  devSelT      dev;
  logic        ci;
  portT        port;
  logic        io;
  logic        berr;
} vecT;

// memSelT bit order is rom, dev, mmio, dram[3:0]
localparam memSelT memNone  = 7'b000_0000;
localparam memSelT memRom   = 7'b100_0000;
localparam memSelT memDev   = 7'b010_0000;
localparam memSelT memMmio  = 7'b001_0000;
localparam memSelT memBank0 = 7'b000_0001;
localparam memSelT memBank1 = 7'b000_0010;
localparam memSelT memBank2 = 7'b000_0100;
localparam memSelT memBank3 = 7'b000_1000;

// devSelT bit order is duart, tmr, ata, i2c, intc, ext
localparam devSelT devNone  = 6'b000000;
localparam devSelT devDuart = 6'b100000;
localparam devSelT devTmr   = 6'b010000;
localparam devSelT devAta   = 6'b001000;
localparam devSelT devI2c   = 6'b000100;
localparam devSelT devIntc  = 6'b000010;
localparam devSelT devExt   = 6'b000001;

localparam int numVecs = 25;

// base, mask, fc, rnW, siz, mem, dev, ci, port, io, berr
vecT vecs [numVecs] = '{
  // Bank 0 reads come from ROM while booting
  '{32'h0, 32'h0, superProg, 1'b1, 2'd0, memRom, devNone, 1'b1, port16, 1'b0, 1'b0},
  '{32'h0, 32'h0, superProg, 1'b1, 2'd0, memRom, devNone, 1'b1, port16, 1'b0, 1'b0},
  '{32'h0, 32'h0, superProg, 1'b1, 2'd0, memRom, devNone, 1'b1, port16, 1'b0, 1'b0},
  '{32'h0, 32'h0, superProg, 1'b1, 2'd0, memRom, devNone, 1'b1, port16, 1'b0, 1'b0},
  // DRAM has no terminator once the overlay is gone
  '{32'h0, 32'h0FFFFFFF, superData, 1'b1, 2'd0, memBank0, devNone, 1'b0, portNone, 1'b0, 1'b1},
  // Region map
  '{32'h80000000, 32'h3FFFFFFF, superData, 1'b1, 2'd0, memMmio, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  '{32'h10000000, 32'h0FFFFFFF, userData, 1'b0, 2'd0, memBank1, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  '{32'h20000000, 32'h0FFFFFFF, userProg, 1'b1, 2'd0, memBank2, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  '{32'h30000000, 32'h0FFFFFFF, superData, 1'b0, 2'd0, memBank3, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  '{32'hFFF00000, 32'h000FFFFF, superProg, 1'b1, 2'd0, memRom, devNone, 1'b0, port16, 1'b0, 1'b0},
  // ROM write, reserved space and CPU space select nothing
  '{32'hFFF00000, 32'h000FFFFF, superData, 1'b0, 2'd0, memNone, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  '{32'hFFF00000, 32'h000FFFFF, reserved3, 1'b1, 2'd0, memNone, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  '{32'hFFF00000, 32'h000FFFFF, cpuSpace, 1'b1, 2'd0, memNone, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  // Peripherals
  '{32'hFFE00000, 32'hF, superData, 1'b1, 2'd1, memDev, devDuart, 1'b1, port8, 1'b0, 1'b0},
  '{32'hFFE00000, 32'hF, superData, 1'b0, 2'd1, memDev, devDuart, 1'b1, port8, 1'b0, 1'b0},
  '{32'hFFE00010, 32'hF, superData, 1'b1, 2'd1, memDev, devTmr, 1'b1, port8, 1'b1, 1'b0},
  '{32'hFFE00010, 32'hF, superData, 1'b0, 2'd1, memDev, devTmr, 1'b1, port8, 1'b1, 1'b0},
  '{32'hFFE00020, 32'hF, superData, 1'b1, 2'd2, memDev, devAta, 1'b1, portNone, 1'b0, 1'b1},
  '{32'hFFE00100, 32'hF, superData, 1'b0, 2'd1, memDev, devI2c, 1'b1, portNone, 1'b0, 1'b1},
  '{32'hFFEFFFF0, 32'hF, superData, 1'b1, 2'd1, memDev, devIntc, 1'b1, portNone, 1'b0, 1'b1},
  // Unmatched offsets go off-board with a strobe
  '{32'hFFE40000, 32'hFFFF, superData, 1'b1, 2'd1, memDev, devExt, 1'b1, portNone, 1'b1, 1'b1},
  '{32'hFFE40000, 32'hFFFF, superData, 1'b0, 2'd1, memDev, devExt, 1'b1, portNone, 1'b1, 1'b1},
  // Gap between DRAM and MMIO
  '{32'h40000000, 32'h3FFFFFFF, superData, 1'b1, 2'd0, memNone, devNone, 1'b0, portNone,
    1'b0, 1'b1},
  // Back-to-back timer accesses through the recovery states
  '{32'hFFE00010, 32'hF, userData, 1'b0, 2'd1, memDev, devTmr, 1'b1, port8, 1'b1, 1'b0},
  '{32'hFFE00010, 32'hF, userData, 1'b1, 2'd1, memDev, devTmr, 1'b1, port8, 1'b1, 1'b0}
};

`endif

//--- tbSysCtl.sv
//##########################################################################
// Testbench for the system controller: clock, reset, vector loop, checks
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module tbSysCtl;

  import sysMapPkg::*;
  import busPkg::*;

  // Limit for every handshake wait
  localparam int timeoutCycles = 100;

  logic   CPU_CLK;
  logic   nRST;
  cpuBusT cpuBus;
  memSelT memSel;
  devSelT devSel;
  portT   dsack;
  logic   ci;
  logic   berr;
  logic   ioRd;
  logic   ioWr;

  int     errors;
  int     timeouts;
  logic   timedOut;

  `include "tbVectors.svh"

  sysCtl sysCtl_i (
    .CPU_CLK (CPU_CLK),
    .nRST    (nRST),
    .cpuBus  (cpuBus),
    .memSel  (memSel),
    .devSel  (devSel),
    .dsack   (dsack),
    .ci      (ci),
    .berr    (berr),
    .ioRd    (ioRd),
    .ioWr    (ioWr)
  );

  // 10 ns CPU clock
  always #5 CPU_CLK = ~CPU_CLK;

  // Selects are combinational, valid once nDs is low
  task automatic checkSelects(input int idx, input vecT v);
    assert (memSel == v.mem) else begin
      $display("ERR %0t: vector %0d memSel %b, expected %b", $time, idx, memSel, v.mem);
      errors++;
    end
    assert (devSel == v.dev) else begin
      $display("ERR %0t: vector %0d devSel %b, expected %b", $time, idx, devSel, v.dev);
      errors++;
    end
    assert (ci == v.ci) else begin
      $display("ERR %0t: vector %0d ci %b, expected %b", $time, idx, ci, v.ci);
      errors++;
    end
  endtask

  // Sampled on the clock where dsack or berr first shows
  task automatic checkTermination(input int idx, input vecT v);
    assert (dsack == v.port) else begin
      $display("ERR %0t: vector %0d dsack %b, expected %b", $time, idx, dsack, v.port);
      errors++;
    end
    assert (berr == v.berr) else begin
      $display("ERR %0t: vector %0d berr %b, expected %b", $time, idx, berr, v.berr);
      errors++;
    end
    // Strobe direction follows rnW
    assert (ioRd == (v.io & v.rnW) && ioWr == (v.io & ~v.rnW)) else begin
      $display("ERR %0t: vector %0d ioRd %b ioWr %b, strobe expected %b", $time, idx,
               ioRd, ioWr, v.io);
      errors++;
    end
  endtask

  // Wait for DSACK or BERR
  task automatic waitTermination(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CPU_CLK);
      cycles++;
    end while (dsack == portNone && !berr && cycles < timeoutCycles);
    if (dsack == portNone && !berr) begin
      $display("Timeout: vector %0d got neither dsack nor berr in %0d cycles", idx,
               timeoutCycles);
      timeouts++;
      timedOut = 1'b1;
    end
  endtask

  // Wait for DSACK and BERR to drop after nAs rose
  task automatic waitRelease(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CPU_CLK);
      cycles++;
    end while ((dsack != portNone || berr) && cycles < timeoutCycles);
    if (dsack != portNone || berr) begin
      $display("Timeout: vector %0d still shows dsack or berr after nAs went high", idx);
      timeouts++;
      timedOut = 1'b1;
    end
  endtask

  // One full 68030-style bus cycle
  task automatic playVector(input int idx, input vecT v);
    @(posedge CPU_CLK);
    cpuBus.addr <= v.base | ($urandom & v.mask);
    cpuBus.fc   <= v.fc;
    cpuBus.rnW  <= v.rnW;
    cpuBus.siz  <= v.siz;
    cpuBus.nAs  <= 1'b0;
    // nDs one clock behind nAs
    @(posedge CPU_CLK);
    cpuBus.nDs <= 1'b0;
    @(negedge CPU_CLK);
    checkSelects(idx, v);
    waitTermination(idx);
    if (!timedOut) begin
      checkTermination(idx, v);
      @(posedge CPU_CLK);
      cpuBus.nDs <= 1'b1;
      @(negedge CPU_CLK);
      // dsack is gated by nDs, no clock needed
      assert (dsack == portNone) else begin
        $display("ERR %0t: vector %0d dsack %b still set with nDs high", $time, idx, dsack);
        errors++;
      end
      @(posedge CPU_CLK);
      cpuBus.nAs <= 1'b1;
      waitRelease(idx);
    end
  endtask

  initial begin
    CPU_CLK  = 1'b0;
    nRST     = 1'b0;
    cpuBus   = '{nAs: 1'b1, nDs: 1'b1, rnW: 1'b1, siz: 2'b00, fc: userData, addr: '0};
    errors   = 0;
    timeouts = 0;
    timedOut = 1'b0;
    void'($urandom(32'h990c_8f34));

    repeat (16) @(posedge CPU_CLK);
    nRST <= 1'b1;
    @(negedge CPU_CLK);
    // Quiet bus, boot overlay armed so ci is up
    assert (dsack == portNone && !berr && !ioRd && !ioWr && ci) else begin
      $display("ERR %0t: outputs after reset dsack %b berr %b ioRd %b ioWr %b ci %b",
               $time, dsack, berr, ioRd, ioWr, ci);
      errors++;
    end

    for (int i = 0; i < numVecs && !timedOut; i++) begin
      playVector(i, vecs[i]);
    end

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
